// ==== Bender.yml ====
package:
  name: datapath

sources:
  - cpuPkg.sv
  - instDecoder.sv
  - regFile.sv
  - alu.sv
  - hazardUnit.sv
  - pipeReg.sv
  - datapath.sv
  - target: simulation
    files:
      - tbDatapath.sv

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpuPkg::word  a,
    input  cpuPkg::word  b,
    input  cpuPkg::aluOp op,
    output cpuPkg::word  result
);

    always_comb begin
        case (op)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOrr: result = a | b;
            cpuPkg::aluNot: result = ~a;
            cpuPkg::aluTcp: result = ~a + 1'b1;
            cpuPkg::aluShift: begin
                if (b[0]) begin
                    result = {a[15], a[15:1]}; // arithmetic
                end else begin
                    result = {a[14:0], 1'b0};
                end
            end
            cpuPkg::aluPassB: result = b; // lhi and link address
            default: result = b;
        endcase
    end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int wordSize = 16;

    typedef logic [wordSize-1:0] word;
    typedef logic [1:0] regAddr;

    // opcode field, instr[15:12]
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opBgz = 4'd2;
    localparam logic [3:0] opBlz = 4'd3;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opOri = 4'd5;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opJal = 4'd10;
    localparam logic [3:0] opRType = 4'd15;

    // func field of the R format, instr[5:0]
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnTcp = 6'd5;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    localparam regAddr linkReg = 2'd2; // return address of jal and jrl

    // first six follow func codes 0..5
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOrr,
        aluNot,
        aluTcp,
        aluShift, // b[0] picks the direction
        aluPassB
    } aluOp;

    typedef enum logic [1:0] {
        fwdNone,
        fwdWb,
        fwdExMem,
        fwdEx     // decode only
    } fwdSel;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrcImm;
        aluOp aluOp;
        logic isWwd;
        logic isHalt;
        logic valid;
    } ctrlT;

    typedef struct packed {
        logic valid;
        word  pc;
        word  instr;
    } ifIdT;

    typedef struct packed {
        ctrlT   ctrl;
        word    pc;
        word    rsVal;
        word    rtVal;
        word    imm;
        regAddr rs;
        regAddr rt;
        regAddr rd;
    } idExT;

    typedef struct packed {
        ctrlT   ctrl;
        word    aluResult;
        word    storeVal;
        word    wwdVal;
        regAddr rd;
    } exMemT;

    typedef struct packed {
        ctrlT   ctrl;
        word    memData;
        word    aluResult;
        word    wwdVal;
        regAddr rd;
    } memWbT;

endpackage

// ==== datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic        clk,
    input  logic        arstN,
    input  cpuPkg::word instData,
    input  cpuPkg::word readData,
    output cpuPkg::word instAddr,
    output logic        instRead,
    output cpuPkg::word dataAddr,
    output logic        dataRead,
    output logic        dataWrite,
    output cpuPkg::word writeData,
    output cpuPkg::word outputPort,
    output logic        outputValid,
    output cpuPkg::word numInst,
    output logic        isHalted
);

    cpuPkg::word pc;
    cpuPkg::word pcNext;
    cpuPkg::word branchTarget;
    cpuPkg::word jumpTarget;

    cpuPkg::ifIdT  ifIdD, ifId;
    cpuPkg::idExT  idExD, idEx;
    cpuPkg::exMemT exMemD, exMem;
    cpuPkg::memWbT memWbD, memWb;

    cpuPkg::ctrlT   decCtrl;
    cpuPkg::regAddr decRs, decRt, decRd;
    cpuPkg::word    decImm;
    logic [3:0]     decOpcode;
    logic           isBranch, isJump, isJumpReg;
    logic           decUsesRs, decUsesRt, decCompare;
    logic           branchTaken, takenCtrl;
    logic           stall, flush, haltNow, haltSeen;

    cpuPkg::fwdSel idFwdA, idFwdB, exFwdA, exFwdB;
    cpuPkg::word   rfRsVal, rfRtVal, idOpA, idOpB;
    cpuPkg::word   exOpA, exOpB, exRtVal, exResult;
    cpuPkg::word   memResult, wbData;

    function automatic cpuPkg::word fwdMux(input cpuPkg::fwdSel sel, input cpuPkg::word base,
                                           input cpuPkg::word exVal, input cpuPkg::word memVal,
                                           input cpuPkg::word wbVal);
        case (sel)
            cpuPkg::fwdEx: return exVal;
            cpuPkg::fwdExMem: return memVal;
            cpuPkg::fwdWb: return wbVal;
            default: return base;
        endcase
    endfunction

    // fetch
    assign instAddr = pc;
    assign instRead = !haltSeen;
    assign branchTarget = ifId.pc + 1'b1 + decImm;
    assign jumpTarget = {ifId.pc[15:12], ifId.instr[11:0]};

    always_comb begin
        if (stall || haltNow || haltSeen) begin
            pcNext = pc;
        end else if (takenCtrl) begin
            if (isJumpReg) begin
                pcNext = idOpA;
            end else if (isJump) begin
                pcNext = jumpTarget;
            end else begin
                pcNext = branchTarget;
            end
        end else begin
            pcNext = pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign ifIdD = '{valid: 1'b1, pc: pc, instr: instData};

    pipeReg #(.payloadT(cpuPkg::ifIdT)) ifIdReg_inst (
        .clk(clk), .arstN(arstN),
        .hold(stall), .bubble(flush || haltNow || haltSeen),
        .d(ifIdD), .q(ifId)
    );

    // decode
    instDecoder instDecoder_inst (
        .instr(ifId.instr), .ctrl(decCtrl),
        .rs(decRs), .rt(decRt), .rd(decRd), .imm(decImm),
        .isBranch(isBranch), .isJump(isJump), .isJumpReg(isJumpReg)
    );

    assign decOpcode = ifId.instr[15:12];
    assign decUsesRs = ifId.valid && !isJump;
    assign decUsesRt = ifId.valid && (decOpcode == cpuPkg::opRType || decOpcode == cpuPkg::opSwd
                                      || decOpcode == cpuPkg::opBeq
                                      || decOpcode == cpuPkg::opBne);
    assign decCompare = isBranch || isJumpReg;

    regFile regFile_inst (
        .clk(clk), .arstN(arstN),
        .rs(decRs), .rt(decRt),
        .wrAddr(memWb.rd), .wrData(wbData),
        .wrEn(memWb.ctrl.valid && memWb.ctrl.regWrite),
        .rsVal(rfRsVal), .rtVal(rfRtVal)
    );

    hazardUnit hazardUnit_inst (
        .decRs(decRs), .decRt(decRt),
        .decUsesRs(decUsesRs), .decUsesRt(decUsesRt),
        .idEx(idEx), .exMem(exMem), .memWb(memWb),
        .idFwdA(idFwdA), .idFwdB(idFwdB), .exFwdA(exFwdA), .exFwdB(exFwdB),
        .stall(stall), .flush(flush),
        .takenCtrl(takenCtrl), .decCompare(decCompare)
    );

    assign idOpA = fwdMux(idFwdA, rfRsVal, exResult, memResult, wbData);
    assign idOpB = fwdMux(idFwdB, rfRtVal, exResult, memResult, wbData);

    always_comb begin
        case (decOpcode)
            cpuPkg::opBne: branchTaken = idOpA != idOpB;
            cpuPkg::opBeq: branchTaken = idOpA == idOpB;
            cpuPkg::opBgz: branchTaken = $signed(idOpA) > 0;
            cpuPkg::opBlz: branchTaken = $signed(idOpA) < 0;
            default: branchTaken = 1'b0;
        endcase
    end

    assign takenCtrl = ifId.valid && ((isBranch && branchTaken) || isJump || isJumpReg);
    assign haltNow = ifId.valid && decCtrl.isHalt && !stall;

    always_comb begin
        idExD.ctrl = ifId.valid ? decCtrl : '0;
        idExD.pc = ifId.pc;
        idExD.rsVal = idOpA;
        idExD.rtVal = idOpB;
        idExD.imm = decImm;
        idExD.rs = decRs;
        idExD.rt = decRt;
        idExD.rd = decRd;
    end

    pipeReg #(.payloadT(cpuPkg::idExT)) idExReg_inst (
        .clk(clk), .arstN(arstN),
        .hold(1'b0), .bubble(stall),
        .d(idExD), .q(idEx)
    );

    // execute
    assign exOpA = fwdMux(exFwdA, idEx.rsVal, idEx.rsVal, memResult, wbData);
    assign exRtVal = fwdMux(exFwdB, idEx.rtVal, idEx.rtVal, memResult, wbData);
    assign exOpB = idEx.ctrl.aluSrcImm ? idEx.imm :
                   (idEx.ctrl.aluOp == cpuPkg::aluPassB) ? idEx.pc + 1'b1 : exRtVal;

    alu alu_inst (.a(exOpA), .b(exOpB), .op(idEx.ctrl.aluOp), .result(exResult));

    assign exMemD = '{ctrl: idEx.ctrl, aluResult: exResult, storeVal: exRtVal,
                      wwdVal: exOpA, rd: idEx.rd};

    pipeReg #(.payloadT(cpuPkg::exMemT)) exMemReg_inst (
        .clk(clk), .arstN(arstN),
        .hold(1'b0), .bubble(1'b0),
        .d(exMemD), .q(exMem)
    );

    // memory
    assign dataAddr = exMem.aluResult;
    assign dataRead = exMem.ctrl.valid && exMem.ctrl.memRead;
    assign dataWrite = exMem.ctrl.valid && exMem.ctrl.memWrite;
    assign writeData = exMem.storeVal;
    assign memResult = exMem.ctrl.memToReg ? readData : exMem.aluResult; // forwarded value

    assign memWbD = '{ctrl: exMem.ctrl, memData: readData, aluResult: exMem.aluResult,
                      wwdVal: exMem.wwdVal, rd: exMem.rd};

    pipeReg #(.payloadT(cpuPkg::memWbT)) memWbReg_inst (
        .clk(clk), .arstN(arstN),
        .hold(1'b0), .bubble(1'b0),
        .d(memWbD), .q(memWb)
    );

    // writeback and status
    assign wbData = memWb.ctrl.memToReg ? memWb.memData : memWb.aluResult;
    assign outputPort = memWb.wwdVal;
    assign outputValid = memWb.ctrl.valid && memWb.ctrl.isWwd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            numInst <= '0;
            isHalted <= 1'b0;
            haltSeen <= 1'b0;
        end else begin
            if (memWb.ctrl.valid) begin
                numInst <= numInst + 1'b1;
            end
            if (memWb.ctrl.valid && memWb.ctrl.isHalt) begin
                isHalted <= 1'b1;
            end
            if (haltNow) begin
                haltSeen <= 1'b1; // fetch frozen from here on
            end
        end
    end

    // nothing younger than HLT may reach writeback
    noRetireAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
        isHalted |-> !memWb.ctrl.valid);

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  cpuPkg::regAddr decRs,
    input  cpuPkg::regAddr decRt,
    input  logic           decUsesRs,
    input  logic           decUsesRt,
    input  cpuPkg::idExT   idEx,
    input  cpuPkg::exMemT  exMem,
    input  cpuPkg::memWbT  memWb,
    output cpuPkg::fwdSel  idFwdA,
    output cpuPkg::fwdSel  idFwdB,
    output cpuPkg::fwdSel  exFwdA,
    output cpuPkg::fwdSel  exFwdB,
    output logic           stall,
    output logic           flush,
    input  logic           takenCtrl,
    input  logic           decCompare
);

    logic exWrites;
    logic memWrites;
    logic wbWrites;
    logic rsHit;
    logic rtHit;

    assign exWrites = idEx.ctrl.valid && idEx.ctrl.regWrite;
    assign memWrites = exMem.ctrl.valid && exMem.ctrl.regWrite;
    assign wbWrites = memWb.ctrl.valid && memWb.ctrl.regWrite;

    // youngest producer wins
    function automatic cpuPkg::fwdSel laterSrc(input cpuPkg::regAddr r);
        if (memWrites && exMem.rd == r) return cpuPkg::fwdExMem;
        if (wbWrites && memWb.rd == r) return cpuPkg::fwdWb;
        return cpuPkg::fwdNone;
    endfunction

    function automatic cpuPkg::fwdSel decSrc(input cpuPkg::regAddr r, input logic used);
        if (!used) return cpuPkg::fwdNone;
        if (exWrites && idEx.rd == r) return cpuPkg::fwdEx;
        return laterSrc(r);
    endfunction

    always_comb begin
        idFwdA = decSrc(decRs, decUsesRs);
        idFwdB = decSrc(decRt, decUsesRt);
        exFwdA = laterSrc(idEx.rs);
        exFwdB = laterSrc(idEx.rt);
    end

    assign rsHit = decUsesRs && exWrites && idEx.rd == decRs;
    assign rtHit = decUsesRt && exWrites && idEx.rd == decRt;

    // load data not ready yet and the compare may not take the ALU output
    assign stall = (rsHit || rtHit) && (idEx.ctrl.memRead || decCompare);
    assign flush = takenCtrl && !stall;

endmodule

// ==== instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder (
    input  cpuPkg::word    instr,
    output cpuPkg::ctrlT   ctrl,
    output cpuPkg::regAddr rs,
    output cpuPkg::regAddr rt,
    output cpuPkg::regAddr rd,
    output cpuPkg::word    imm,
    output logic           isBranch,
    output logic           isJump,
    output logic           isJumpReg
);

    logic [3:0] opcode;
    logic [5:0] func;
    cpuPkg::word immSext;

    assign opcode = instr[15:12];
    assign func = instr[5:0];
    assign rs = instr[11:10];
    assign rt = instr[9:8];
    assign immSext = {{8{instr[7]}}, instr[7:0]};

    always_comb begin
        ctrl = '0;
        ctrl.valid = 1'b1;
        rd = instr[9:8]; // immediate and load write rt
        imm = immSext;
        isBranch = 1'b0;
        isJump = 1'b0;
        isJumpReg = 1'b0;
        case (opcode)
            cpuPkg::opBne, cpuPkg::opBeq, cpuPkg::opBgz, cpuPkg::opBlz: begin
                isBranch = 1'b1;
            end
            cpuPkg::opAdi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = cpuPkg::aluOrr;
                imm = {8'h00, instr[7:0]};
            end
            cpuPkg::opLhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = cpuPkg::aluPassB;
                imm = {instr[7:0], 8'h00};
            end
            cpuPkg::opLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::opSwd: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::opJmp: isJump = 1'b1;
            cpuPkg::opJal: begin
                isJump = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = cpuPkg::aluPassB; // pass b without imm means link
                rd = cpuPkg::linkReg;
            end
            cpuPkg::opRType: begin
                rd = instr[7:6];
                case (func)
                    cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd,
                    cpuPkg::fnOrr, cpuPkg::fnNot, cpuPkg::fnTcp: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = cpuPkg::aluOp'(func[2:0]);
                    end
                    cpuPkg::fnShl, cpuPkg::fnShr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluSrcImm = 1'b1;
                        ctrl.aluOp = cpuPkg::aluShift;
                        imm = {{(cpuPkg::wordSize-1){1'b0}}, func[0]}; // 1 for shr
                    end
                    cpuPkg::fnJpr: isJumpReg = 1'b1;
                    cpuPkg::fnJrl: begin
                        isJumpReg = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = cpuPkg::aluPassB;
                        rd = cpuPkg::linkReg;
                    end
                    cpuPkg::fnWwd: ctrl.isWwd = 1'b1;
                    cpuPkg::fnHlt: ctrl.isHalt = 1'b1;
                    default: ; // retires as a no-op
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    hold,
    input  logic    bubble,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0; // valid bit cleared
        end else if (!hold) begin
            q <= d;
        end
    end

    holdBubbleExcl: assert property (@(posedge clk) disable iff (!arstN) !(hold && bubble));

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::regAddr rs,
    input  cpuPkg::regAddr rt,
    input  cpuPkg::regAddr wrAddr,
    input  cpuPkg::word    wrData,
    input  logic           wrEn,
    output cpuPkg::word    rsVal,
    output cpuPkg::word    rtVal
);

    cpuPkg::word regs [4];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // writeback lands in the same cycle decode reads
    assign rsVal = (wrEn && wrAddr == rs) ? wrData : regs[rs];
    assign rtVal = (wrEn && wrAddr == rt) ? wrData : regs[rt];

endmodule

// ==== tbDatapath.sv ====
`timescale 1ns/1ps

module tbDatapath;

    typedef struct packed {
        logic [15:0][15:0] prog;
        cpuPkg::word       dataInit; // word at data address 32
        logic [3:0][15:0]  wwd;
        logic [2:0]        wwdCount;
        logic [7:0]        expNum;
    } testCaseT;

    logic        clk = 1'b0;
    logic        arstN;
    cpuPkg::word instData;
    cpuPkg::word readData;
    cpuPkg::word instAddr;
    logic        instRead;
    cpuPkg::word dataAddr;
    logic        dataRead;
    logic        dataWrite;
    cpuPkg::word writeData;
    cpuPkg::word outputPort;
    logic        outputValid;
    cpuPkg::word numInst;
    logic        isHalted;

    cpuPkg::word imem [16];
    cpuPkg::word dmem [64];
    cpuPkg::word captured [$];

    testCaseT tests [5];
    testCaseT tc;
    int       curPc;
    int       numCases = 0;
    int       errors = 0;
    int       checks = 0;

    always #10 clk = ~clk;

    datapath datapath_inst (
        .clk(clk), .arstN(arstN),
        .instData(instData), .readData(readData),
        .instAddr(instAddr), .instRead(instRead),
        .dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
        .writeData(writeData), .outputPort(outputPort), .outputValid(outputValid),
        .numInst(numInst), .isHalted(isHalted)
    );

    // both memories answer in the same cycle
    assign instData = imem[instAddr[3:0]];
    assign readData = dataRead ? dmem[dataAddr[5:0]] : '0; // only while strobed

    always @(posedge clk) begin
        if (dataWrite) begin
            dmem[dataAddr[5:0]] <= writeData;
        end
    end

    always @(negedge clk) begin
        if (arstN && outputValid) begin
            captured.push_back(outputPort);
        end
    end

    function automatic cpuPkg::word rInst(input cpuPkg::regAddr rs, input cpuPkg::regAddr rt,
                                          input cpuPkg::regAddr rd, input logic [5:0] fn);
        return {cpuPkg::opRType, rs, rt, rd, fn};
    endfunction

    function automatic cpuPkg::word iInst(input logic [3:0] op, input cpuPkg::regAddr rs,
                                          input cpuPkg::regAddr rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpuPkg::word jInst(input logic [3:0] op, input logic [11:0] target);
        return {op, target};
    endfunction

    task automatic newCase(input cpuPkg::word dataInit);
        tc = '0;
        for (int i = 0; i < 16; i++) begin
            tc.prog[i] = rInst(0, 0, 0, cpuPkg::fnHlt); // unused words halt
        end
        tc.dataInit = dataInit;
        curPc = 0;
    endtask

    task automatic addInst(input cpuPkg::word w);
        tc.prog[curPc] = w;
        curPc++;
    endtask

    task automatic addWwd(input cpuPkg::word v);
        tc.wwd[tc.wwdCount] = v;
        tc.wwdCount = tc.wwdCount + 1'b1;
    endtask

    task automatic closeCase(input logic [7:0] expNum);
        tc.expNum = expNum;
        tests[numCases] = tc;
        numCases++;
    endtask

    task automatic buildTable();
        // ALU chain at distances 1 to 3
        newCase(16'h0000);
        addInst(iInst(cpuPkg::opLhi, 0, 1, 8'h12));   // r1 = 1200
        addInst(iInst(cpuPkg::opOri, 1, 1, 8'h34));   // r1 = 1234
        addInst(iInst(cpuPkg::opAdi, 1, 2, 8'hfc));   // r2 = 1230
        addInst(rInst(1, 2, 3, cpuPkg::fnAdd));       // r3 = 2464
        addInst(rInst(3, 1, 0, cpuPkg::fnSub));       // r0 = 1230
        addInst(rInst(0, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(3, 1, 2, cpuPkg::fnAnd));       // r2 = 0024
        addInst(rInst(2, 0, 2, cpuPkg::fnOrr));       // r2 = 1234
        addInst(rInst(2, 0, 3, cpuPkg::fnNot));       // r3 = edcb
        addInst(rInst(3, 0, 1, cpuPkg::fnTcp));       // r1 = 1235
        addInst(rInst(1, 0, 1, cpuPkg::fnShl));       // r1 = 246a
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(3, 0, 3, cpuPkg::fnShr));       // r3 = f6e5
        addInst(rInst(3, 0, 0, cpuPkg::fnWwd));
        addWwd(16'h1230);
        addWwd(16'h246a);
        addWwd(16'hf6e5);
        closeCase(15);

        // load-use stalls and a store then load
        newCase(16'h1357);
        addInst(iInst(cpuPkg::opAdi, 0, 1, 8'h20));   // r1 = 32
        addInst(iInst(cpuPkg::opLwd, 1, 2, 8'h00));
        addInst(rInst(2, 2, 3, cpuPkg::fnAdd));       // r3 = 26ae
        addInst(iInst(cpuPkg::opSwd, 1, 3, 8'h01));
        addInst(iInst(cpuPkg::opLwd, 1, 0, 8'h01));
        addInst(rInst(0, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(2, 0, 0, cpuPkg::fnWwd));
        addWwd(16'h26ae);
        addWwd(16'h1357);
        closeCase(8);

        // each branch taken and not taken with wwd in the skipped slots
        newCase(16'h0000);
        addInst(iInst(cpuPkg::opAdi, 0, 1, 8'h05));   // r1 = 5
        addInst(iInst(cpuPkg::opAdi, 0, 2, 8'hfd));   // r2 = -3
        addInst(iInst(cpuPkg::opBeq, 1, 2, 8'h01));   // not taken
        addInst(iInst(cpuPkg::opBne, 1, 2, 8'h01));
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addInst(iInst(cpuPkg::opBgz, 1, 0, 8'h01));
        addInst(rInst(2, 0, 0, cpuPkg::fnWwd));
        addInst(iInst(cpuPkg::opBlz, 1, 0, 8'h01));   // not taken
        addInst(iInst(cpuPkg::opBlz, 2, 0, 8'h01));
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addInst(iInst(cpuPkg::opBgz, 2, 0, 8'h01));   // not taken
        addInst(iInst(cpuPkg::opBne, 1, 1, 8'h01));   // not taken
        addInst(iInst(cpuPkg::opBeq, 2, 2, 8'h01));
        addInst(rInst(2, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addWwd(16'h0005);
        closeCase(12);

        // jumps and link
        newCase(16'h0000);
        addInst(jInst(cpuPkg::opJmp, 12'd2));
        addInst(rInst(0, 0, 0, cpuPkg::fnWwd));
        addInst(jInst(cpuPkg::opJal, 12'd5));         // r2 = 3
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(0, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(2, 0, 0, cpuPkg::fnWwd));
        addInst(iInst(cpuPkg::opAdi, 0, 1, 8'h0a));   // r1 = 10
        addInst(rInst(1, 0, 0, cpuPkg::fnJrl));       // r2 = 8
        addInst(rInst(0, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(0, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(2, 0, 0, cpuPkg::fnWwd));
        addInst(iInst(cpuPkg::opAdi, 0, 3, 8'h0e));   // r3 = 14
        addInst(rInst(3, 0, 0, cpuPkg::fnJpr));
        addInst(rInst(3, 0, 0, cpuPkg::fnWwd));
        addWwd(16'h0003);
        addWwd(16'h0008);
        closeCase(9);

        // words after hlt never retire
        newCase(16'h0000);
        addInst(iInst(cpuPkg::opAdi, 0, 1, 8'h7f));
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(0, 0, 0, cpuPkg::fnHlt));
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addInst(rInst(1, 0, 0, cpuPkg::fnWwd));
        addWwd(16'h007f);
        closeCase(3);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic runCase(input int p);
        int cycles;
        @(posedge clk);
        #2;
        arstN = 1'b0;
        for (int i = 0; i < 16; i++) begin
            imem[i] = tests[p].prog[i];
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 16'ha500 + i[15:0];
        end
        dmem[32] = tests[p].dataInit;
        captured.delete();
        repeat (8) @(posedge clk);
        #2;
        arstN = 1'b1;

        @(negedge clk); // nothing has left reset state yet
        checkValue("outputValid", 0, outputValid);
        checkValue("dataRead", 0, dataRead);
        checkValue("dataWrite", 0, dataWrite);
        checkValue("isHalted", 0, isHalted);
        checkValue("numInst", 0, numInst);
        checkValue("instRead", 1, instRead);

        cycles = 0;
        while (!isHalted && cycles < 500) begin
            @(negedge clk);
            cycles++;
        end
        if (!isHalted) begin
            errors++;
            $display("program %0d never halted within 500 cycles", p);
        end

        repeat (10) @(negedge clk); // quiet window after halt
        checkValue($sformatf("prog%0d isHalted", p), 1, isHalted);
        checkValue($sformatf("prog%0d numInst", p), tests[p].expNum, numInst);
        checkValue($sformatf("prog%0d wwdCount", p), tests[p].wwdCount, captured.size());
        for (int i = 0; i < tests[p].wwdCount && i < captured.size(); i++) begin
            checkValue($sformatf("prog%0d outputPort[%0d]", p, i), tests[p].wwd[i],
                       captured[i]);
        end
    endtask

    initial begin
        arstN = 1'b0;
        buildTable();
        for (int p = 0; p < numCases; p++) begin
            runCase(p);
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
cpuPkg.sv
instDecoder.sv
regFile.sv
alu.sv
hazardUnit.sv
pipeReg.sv
datapath.sv
tbDatapath.sv
